// File: draw_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, screen bounds, opcodes
// and state encodings of the draw engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package draw_pkg;

    // coordinate and colour sizes
    localparam int cordw = 10;  // fits 0..1023, unsigned
    localparam int colw  = 8;   // colour index

    // visible area; a pixel is drawn when x < h_res and y < v_res
    localparam logic [cordw-1:0] h_res = 10'd640;
    localparam logic [cordw-1:0] v_res = 10'd480;

    // command opcodes
    typedef enum logic [1:0] {
        op_line = 2'd0,  // bresenham line p0 -> p1
        op_tri  = 2'd1,  // triangle outline, three edges
        op_rect = 2'd2   // solid box, p0/p1 opposite corners
    } draw_op_e;

    // sequencer states of draw_ctrl
    typedef enum logic [2:0] {
        s_idle   = 3'd0,  // waiting for a command
        s_line   = 3'd1,  // single line running
        s_edge0  = 3'd2,  // tri edge p0 -> p1
        s_edge1  = 3'd3,  // tri edge p1 -> p2
        s_edge2  = 3'd4,  // tri edge p2 -> p0
        s_rect   = 3'd5,  // rectangle fill running
        s_finish = 3'd6   // drain output stage, then done
    } ctrl_state_e;

    // line stepper states
    typedef enum logic [1:0] {
        l_idle = 2'd0,
        l_init = 2'd1,  // error term setup
        l_draw = 2'd2   // one pixel per accepted cycle
    } line_state_e;

    // rectangle scanner states
    typedef enum logic {
        r_idle = 1'b0,
        r_scan = 1'b1
    } rect_state_e;

endpackage

// File: line_raster.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bresenham line stepper with a
// valid/ready pixel output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module line_raster (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,  // one-cycle kick, endpoints valid here
    input  logic [draw_pkg::cordw-1:0] x0,
    input  logic [draw_pkg::cordw-1:0] y0,
    input  logic [draw_pkg::cordw-1:0] x1,
    input  logic [draw_pkg::cordw-1:0] y1,
    output logic                       valid,
    output logic [draw_pkg::cordw-1:0] x,
    output logic [draw_pkg::cordw-1:0] y,
    input  logic                       ready,
    output logic                       done    // cycle after endpoint taken
);
    import draw_pkg::*;

    line_state_e state;

    logic [cordw-1:0]        x_end, y_end;   // latched endpoint
    logic                    right, down;    // step direction
    logic [cordw-1:0]        adx, ady;       // |x1-x0|, |y1-y0|
    logic signed [cordw+1:0] dx, dy;         // dx = |dx|, dy = -|dy|
    logic signed [cordw+1:0] err, err_next;
    logic signed [cordw+2:0] e2;             // twice the error
    logic                    step_x, step_y;
    logic                    at_end, take;

    // delta magnitudes straight from the start inputs
    always_comb begin
        adx = (x1 >= x0) ? x1 - x0 : x0 - x1;
        ady = (y1 >= y0) ? y1 - y0 : y0 - y1;
    end

    assign valid  = (state == l_draw);
    assign take   = valid && ready;            // pixel leaves this cycle
    assign at_end = (x == x_end) && (y == y_end);

    // error rule
    assign e2     = {err, 1'b0};
    assign step_x = (e2 >= dy);                // 2e >= -|dy|
    assign step_y = (e2 <= dx);                // 2e <= dx

    always_comb begin
        err_next = err;
        if (step_x) err_next = err_next + dy;
        if (step_y) err_next = err_next + dx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= l_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                l_idle: begin
                    if (start) state <= l_init;
                end
                l_init: begin
                    state <= l_draw;
                end
                l_draw: begin
                    if (take && at_end) begin
                        state <= l_idle;
                        done  <= 1'b1;         // endpoint accepted
                    end
                end
                default: begin
                    state <= l_idle;
                end
            endcase
        end
    end

    // position and error term
    always_ff @(posedge clk) begin
        if (state == l_idle && start) begin
            x     <= x0;
            y     <= y0;
            x_end <= x1;
            y_end <= y1;
            right <= (x1 > x0);
            down  <= (y1 > y0);
            dx    <= $signed({2'b00, adx});
            dy    <= -$signed({2'b00, ady});
        end
        if (state == l_init) err <= dx + dy;   // dx - |dy|
        if (take && !at_end) begin
            if (step_x) x <= right ? x + 1'b1 : x - 1'b1;
            if (step_y) y <= down ? y + 1'b1 : y - 1'b1;
            err <= err_next;
        end
    end

endmodule

// File: rect_fill.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// solid rectangle scanner, row-major
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module rect_fill (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,  // corners valid here
    input  logic [draw_pkg::cordw-1:0] x0,     // left
    input  logic [draw_pkg::cordw-1:0] y0,     // top
    input  logic [draw_pkg::cordw-1:0] x1,     // right
    input  logic [draw_pkg::cordw-1:0] y1,     // bottom
    output logic                       valid,
    output logic [draw_pkg::cordw-1:0] x,
    output logic [draw_pkg::cordw-1:0] y,
    input  logic                       ready,
    output logic                       done
);
    import draw_pkg::*;

    rect_state_e state;

    logic [cordw-1:0] x_left, x_right, y_bot;  // scan limits
    logic             row_end, last, take;

    assign valid   = (state == r_scan);
    assign take    = valid && ready;
    assign row_end = (x == x_right);
    assign last    = row_end && (y == y_bot);   // bottom-right corner

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= r_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                r_idle: begin
                    if (start) state <= r_scan;  // first pixel next cycle
                end
                r_scan: begin
                    if (take && last) begin
                        state <= r_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= r_idle;
                end
            endcase
        end
    end

    // row/column counter
    always_ff @(posedge clk) begin
        if (state == r_idle && start) begin
            x       <= x0;
            y       <= y0;
            x_left  <= x0;
            x_right <= x1;
            y_bot   <= y1;
        end else if (take && !last) begin
            if (row_end) begin
                x <= x_left;                 // wrap to next row
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

endmodule

// File: draw_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command handshake, opcode sequencer
// and pixel source select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module draw_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  draw_pkg::draw_op_e         cmd_op,
    input  logic [draw_pkg::cordw-1:0] cmd_x0,
    input  logic [draw_pkg::cordw-1:0] cmd_y0,
    input  logic [draw_pkg::cordw-1:0] cmd_x1,
    input  logic [draw_pkg::cordw-1:0] cmd_y1,
    input  logic [draw_pkg::cordw-1:0] cmd_x2,
    input  logic [draw_pkg::cordw-1:0] cmd_y2,
    input  logic [draw_pkg::colw-1:0]  cmd_color,
    output logic                       ln_start,
    output logic [draw_pkg::cordw-1:0] ln_x0,
    output logic [draw_pkg::cordw-1:0] ln_y0,
    output logic [draw_pkg::cordw-1:0] ln_x1,
    output logic [draw_pkg::cordw-1:0] ln_y1,
    input  logic                       ln_valid,
    input  logic [draw_pkg::cordw-1:0] ln_x,
    input  logic [draw_pkg::cordw-1:0] ln_y,
    output logic                       ln_ready,
    input  logic                       ln_done,
    output logic                       rc_start,
    output logic [draw_pkg::cordw-1:0] rc_x0,
    output logic [draw_pkg::cordw-1:0] rc_y0,
    output logic [draw_pkg::cordw-1:0] rc_x1,
    output logic [draw_pkg::cordw-1:0] rc_y1,
    input  logic                       rc_valid,
    input  logic [draw_pkg::cordw-1:0] rc_x,
    input  logic [draw_pkg::cordw-1:0] rc_y,
    output logic                       rc_ready,
    input  logic                       rc_done,
    output logic                       px_valid,
    output logic [draw_pkg::cordw-1:0] px_x,
    output logic [draw_pkg::cordw-1:0] px_y,
    output logic [draw_pkg::colw-1:0]  px_color,
    input  logic                       px_ready,
    input  logic                       px_empty,
    output logic                       busy,
    output logic                       done
);
    import draw_pkg::*;

    ctrl_state_e state;

    logic [cordw-1:0] p0x, p0y, p1x, p1y, p2x, p2y;  // latched vertices
    logic [colw-1:0]  color;
    logic             take_cmd, line_mode, rect_mode;

    assign take_cmd  = cmd_valid && cmd_ready;
    assign line_mode = (state == s_line) || (state == s_edge0) ||
                       (state == s_edge1) || (state == s_edge2);
    assign rect_mode = (state == s_rect);
    assign busy      = (state != s_idle);

    // ready only to the raster that owns the stream
    assign ln_ready = line_mode && px_ready;
    assign rc_ready = rect_mode && px_ready;
    assign px_color = color;

    always_comb begin
        px_valid = 1'b0;
        px_x     = ln_x;
        px_y     = ln_y;
        if (rect_mode) begin
            px_valid = rc_valid;
            px_x     = rc_x;
            px_y     = rc_y;
        end else if (line_mode) begin
            px_valid = ln_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= s_idle;
            cmd_ready <= 1'b0;
            ln_start  <= 1'b0;
            rc_start  <= 1'b0;
            done      <= 1'b0;
        end else begin
            ln_start <= 1'b0;
            rc_start <= 1'b0;
            done     <= 1'b0;
            case (state)
                s_idle: begin
                    cmd_ready <= 1'b1;
                    if (take_cmd) begin
                        cmd_ready <= 1'b0;
                        case (cmd_op)
                            op_line: begin
                                ln_start <= 1'b1;
                                state    <= s_line;
                            end
                            op_tri: begin
                                ln_start <= 1'b1;  // edge p0 -> p1
                                state    <= s_edge0;
                            end
                            op_rect: begin
                                rc_start <= 1'b1;
                                state    <= s_rect;
                            end
                            default: state <= s_finish;  // unknown op, no pixels
                        endcase
                    end
                end
                s_line:  if (ln_done) state <= s_finish;
                s_edge0: begin
                    if (ln_done) begin
                        ln_start <= 1'b1;          // edge p1 -> p2
                        state    <= s_edge1;
                    end
                end
                s_edge1: begin
                    if (ln_done) begin
                        ln_start <= 1'b1;          // closing edge p2 -> p0
                        state    <= s_edge2;
                    end
                end
                s_edge2: if (ln_done) state <= s_finish;
                s_rect:  if (rc_done) state <= s_finish;
                s_finish: begin
                    if (px_empty) begin            // last pixel has left
                        done  <= 1'b1;
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // command latch and raster endpoints
    always_ff @(posedge clk) begin
        if (take_cmd) begin
            p0x   <= cmd_x0;
            p0y   <= cmd_y0;
            p1x   <= cmd_x1;
            p1y   <= cmd_y1;
            p2x   <= cmd_x2;
            p2y   <= cmd_y2;
            color <= cmd_color;
            ln_x0 <= cmd_x0;                       // line and first tri edge
            ln_y0 <= cmd_y0;
            ln_x1 <= cmd_x1;
            ln_y1 <= cmd_y1;
            rc_x0 <= (cmd_x0 < cmd_x1) ? cmd_x0 : cmd_x1;  // sort corners
            rc_y0 <= (cmd_y0 < cmd_y1) ? cmd_y0 : cmd_y1;
            rc_x1 <= (cmd_x0 < cmd_x1) ? cmd_x1 : cmd_x0;
            rc_y1 <= (cmd_y0 < cmd_y1) ? cmd_y1 : cmd_y0;
        end else if (state == s_edge0 && ln_done) begin
            ln_x0 <= p1x;
            ln_y0 <= p1y;
            ln_x1 <= p2x;
            ln_y1 <= p2y;
        end else if (state == s_edge1 && ln_done) begin
            ln_x0 <= p2x;
            ln_y0 <= p2y;
            ln_x1 <= p0x;
            ln_y1 <= p0y;
        end
    end

endmodule

// File: pixel_out.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output register with screen clip
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module pixel_out (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [draw_pkg::cordw-1:0] in_x,
    input  logic [draw_pkg::cordw-1:0] in_y,
    input  logic [draw_pkg::colw-1:0]  in_color,
    output logic                       in_ready,
    output logic                       empty,
    output logic                       pix_valid,
    output logic [draw_pkg::cordw-1:0] pix_x,
    output logic [draw_pkg::cordw-1:0] pix_y,
    output logic [draw_pkg::colw-1:0]  pix_color,
    input  logic                       pix_ready
);
    import draw_pkg::*;

    logic on_screen;
    logic load;

    assign on_screen = (in_x < h_res) && (in_y < v_res);
    assign in_ready  = !pix_valid || pix_ready;  // free, or draining now
    assign empty     = !pix_valid;
    assign load      = in_valid && in_ready;

    // off-screen input is taken but leaves the stage empty
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else if (in_ready) begin
            pix_valid <= in_valid && on_screen;
        end
    end

    // data only moves on load, so it holds under stall
    always_ff @(posedge clk) begin
        if (load) begin
            pix_x     <= in_x;
            pix_y     <= in_y;
            pix_color <= in_color;
        end
    end

endmodule

// File: draw_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// draw engine top: control plus
// line, rectangle and output stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module draw_engine (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  draw_pkg::draw_op_e         cmd_op,
    input  logic [draw_pkg::cordw-1:0] cmd_x0,
    input  logic [draw_pkg::cordw-1:0] cmd_y0,
    input  logic [draw_pkg::cordw-1:0] cmd_x1,
    input  logic [draw_pkg::cordw-1:0] cmd_y1,
    input  logic [draw_pkg::cordw-1:0] cmd_x2,
    input  logic [draw_pkg::cordw-1:0] cmd_y2,
    input  logic [draw_pkg::colw-1:0]  cmd_color,
    output logic                       pix_valid,
    output logic [draw_pkg::cordw-1:0] pix_x,
    output logic [draw_pkg::cordw-1:0] pix_y,
    output logic [draw_pkg::colw-1:0]  pix_color,
    input  logic                       pix_ready,
    output logic                       busy,
    output logic                       done
);
    import draw_pkg::*;

    // line stepper link
    logic             ln_start, ln_valid, ln_ready, ln_done;
    logic [cordw-1:0] ln_x0, ln_y0, ln_x1, ln_y1, ln_x, ln_y;
    // rectangle scanner link
    logic             rc_start, rc_valid, rc_ready, rc_done;
    logic [cordw-1:0] rc_x0, rc_y0, rc_x1, rc_y1, rc_x, rc_y;
    // selected stream into the output stage
    logic             px_valid, px_ready, px_empty;
    logic [cordw-1:0] px_x, px_y;
    logic [colw-1:0]  px_color;

    draw_ctrl i_draw_ctrl (.*);

    line_raster i_line_raster (
        .clk, .rst,
        .start (ln_start), .x0 (ln_x0), .y0 (ln_y0), .x1 (ln_x1), .y1 (ln_y1),
        .valid (ln_valid), .x (ln_x), .y (ln_y), .ready (ln_ready), .done (ln_done)
    );

    rect_fill i_rect_fill (
        .clk, .rst,
        .start (rc_start), .x0 (rc_x0), .y0 (rc_y0), .x1 (rc_x1), .y1 (rc_y1),
        .valid (rc_valid), .x (rc_x), .y (rc_y), .ready (rc_ready), .done (rc_done)
    );

    pixel_out i_pixel_out (
        .clk, .rst,
        .in_valid (px_valid), .in_x (px_x), .in_y (px_y), .in_color (px_color),
        .in_ready (px_ready), .empty (px_empty),
        .pix_valid, .pix_x, .pix_y, .pix_color, .pix_ready
    );

endmodule

// File: draw_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and done pulse checks
// for the draw engine top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module draw_assertions (
    input logic                       clk,
    input logic                       rst,
    input logic                       cmd_ready,
    input logic                       busy,
    input logic                       pix_valid,
    input logic                       pix_ready,
    input logic [draw_pkg::cordw-1:0] pix_x,
    input logic [draw_pkg::cordw-1:0] pix_y,
    input logic [draw_pkg::colw-1:0]  pix_color,
    input logic                       done
);

    int fail_cnt = 0;  // failed assertion count

    // stalled pixel keeps its slot and its data
    a_pix_hold: assert property (@(posedge clk) disable iff (rst)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_x) && $stable(pix_y) &&
                                    $stable(pix_color))
        else begin
            $error("pixel output changed while stalled");
            fail_cnt++;
        end

    a_ready_idle: assert property (@(posedge clk) disable iff (rst) busy |-> !cmd_ready)
        else begin
            $error("cmd_ready high during a draw");  // one command at a time
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done longer than one cycle");
            fail_cnt++;
        end

    a_pix_busy: assert property (@(posedge clk) disable iff (rst) pix_valid |-> busy)
        else begin
            $error("pixel valid with no command running");
            fail_cnt++;
        end

endmodule

// File: tb_draw_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// draw engine testbench: directed tests,
// pixel reference model, timeout, summary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_draw_engine;
    import draw_pkg::*;

    localparam int pw         = colw + 2 * cordw;  // packed {color, x, y}
    localparam int max_cycles = 20000;             // ~1.5k pixels x4, plus margin
    localparam int wait_max   = 3000;              // per handshake or done

    logic             clk, rst;
    logic             cmd_valid, cmd_ready;
    draw_op_e         cmd_op;
    logic [cordw-1:0] cmd_x0, cmd_y0, cmd_x1, cmd_y1, cmd_x2, cmd_y2;
    logic [colw-1:0]  cmd_color;
    logic             pix_valid, pix_ready;
    logic [cordw-1:0] pix_x, pix_y;
    logic [colw-1:0]  pix_color;
    logic             busy, done;

    logic [pw-1:0] exp_q[$];          // model pixels of the running test
    logic [pw-1:0] got_q[$];          // every pixel taken from the dut
    int            done_cnt, busy_errs, cycle_cnt;
    int            tests_ok, tests_bad;
    int            assert_errs;       // failures of the bound assertions
    logic          rand_ready;        // random stall on pix_ready
    logic [31:0]   lcg_state;

    draw_engine i_draw_engine (.*);

    bind draw_engine draw_assertions i_draw_assertions (
        .clk, .rst, .cmd_ready, .busy, .pix_valid, .pix_ready,
        .pix_x, .pix_y, .pix_color, .done
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;        // 10 ns
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string fmt_pix(input logic [pw-1:0] p);
        return $sformatf("(%0d,%0d) color %0h", p[2*cordw-1 -: cordw], p[cordw-1:0],
                         p[pw-1 -: colw]);
    endfunction

    // pixel sink
    initial begin
        pix_ready = 1'b1;
        lcg_state = 32'd2516;
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                lcg_state = lcg_next(lcg_state);
                pix_ready = lcg_state[16];  // mid bit, low bits are weak
            end else begin
                pix_ready = 1'b1;
            end
        end
    end

    // falling edge sample, settled for the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            done_cnt  = 0;
            busy_errs = 0;
        end else begin
            if (pix_valid && pix_ready) got_q.push_back({pix_color, pix_x, pix_y});
            if (done) done_cnt++;
            if (busy && cmd_ready) begin
                $display("cmd_ready was high while the engine was busy");
                busy_errs++;
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles", max_cycles);
        $display("sim failed");
        $finish;
    end

    task automatic push_pixel(input int x, input int y, input logic [colw-1:0] c);
        if (x < int'(h_res) && y < int'(v_res))  // clip to screen
            exp_q.push_back({c, x[cordw-1:0], y[cordw-1:0]});
    endtask

    // bresenham, err = dx - |dy|
    task automatic model_line(input int x0, y0, x1, y1, input logic [colw-1:0] c);
        int dx, ady, sx, sy, err, e2, x, y;
        dx  = (x1 >= x0) ? x1 - x0 : x0 - x1;
        ady = (y1 >= y0) ? y1 - y0 : y0 - y1;
        sx  = (x1 > x0) ? 1 : -1;
        sy  = (y1 > y0) ? 1 : -1;
        err = dx - ady;
        x   = x0;
        y   = y0;
        push_pixel(x, y, c);
        while (x != x1 || y != y1) begin
            e2 = 2 * err;
            if (e2 >= -ady) begin
                err = err - ady;
                x   = x + sx;
            end
            if (e2 <= dx) begin
                err = err + dx;
                y   = y + sy;
            end
            push_pixel(x, y, c);
        end
    endtask

    task automatic model_rect(input int x0, y0, x1, y1, input logic [colw-1:0] c);
        int xl, xr, yt, yb, x, y;
        xl = (x0 < x1) ? x0 : x1;
        xr = (x0 < x1) ? x1 : x0;
        yt = (y0 < y1) ? y0 : y1;
        yb = (y0 < y1) ? y1 : y0;
        for (y = yt; y <= yb; y++)
            for (x = xl; x <= xr; x++)
                push_pixel(x, y, c);   // row-major
    endtask

    task automatic drive_cmd(input draw_op_e op, input int x0, y0, x1, y1, x2, y2,
                             input logic [colw-1:0] c);
        cmd_op    = op;
        cmd_x0    = x0[cordw-1:0];
        cmd_y0    = y0[cordw-1:0];
        cmd_x1    = x1[cordw-1:0];
        cmd_y1    = y1[cordw-1:0];
        cmd_x2    = x2[cordw-1:0];
        cmd_y2    = y2[cordw-1:0];
        cmd_color = c;
        cmd_valid = 1'b1;
    endtask

    task automatic wait_accept(output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < wait_max) begin
            @(negedge clk);
            ok = cmd_ready;
            n++;
        end
        @(posedge clk);            // handshake on this edge
        #1;
    endtask

    task automatic wait_done(input int target, output bit ok);
        int n;
        n = 0;
        while (done_cnt < target && n < wait_max) begin
            @(posedge clk);
            n++;
        end
        ok = (done_cnt >= target);
    endtask

    // one command from accept to done
    task automatic run_cmd(input string name, input draw_op_e op, input int x0, y0, x1, y1,
                           x2, y2, input logic [colw-1:0] c, inout int errs);
        int target;
        bit ok;
        target = done_cnt + 1;
        drive_cmd(op, x0, y0, x1, y1, x2, y2, c);
        wait_accept(ok);
        cmd_valid = 1'b0;
        if (!ok) begin
            $display("%s: command was never accepted", name);
            errs++;
        end else begin
            if (!busy) begin
                $display("%s: busy was low after the command was accepted", name);
                errs++;
            end
            wait_done(target, ok);
            repeat (3) @(posedge clk);   // room for a stray second done
            #1;
            if (!ok) begin
                $display("%s: no done pulse after the command", name);
                errs++;
            end else if (done_cnt != target) begin
                $display("%s: expected one done, counted %0d", name, done_cnt - target + 1);
                errs++;
            end else if (busy) begin
                $display("%s: busy still high after done", name);
                errs++;
            end
        end
    endtask

    task automatic check_pixels(input string name, input int gbase, inout int errs);
        int n, i;
        bit bad;
        n   = got_q.size() - gbase;
        bad = 1'b0;
        if (n != int'(exp_q.size())) begin
            $display("MISMATCH %s pixel count expected %0d actual %0d", name, exp_q.size(), n);
            errs++;
        end
        for (i = 0; i < n && i < int'(exp_q.size()) && !bad; i++) begin
            if (got_q[gbase + i] !== exp_q[i]) begin  // first bad pixel only
                $display("MISMATCH %s pixel %0d expected %s actual %s", name, i,
                         fmt_pix(exp_q[i]), fmt_pix(got_q[gbase + i]));
                errs++;
                bad = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name, input int gbase, input int errs);
        check_pixels(name, gbase, errs);
        if (errs == 0) begin
            tests_ok++;
            $display("test %s ok, %0d pixels", name, got_q.size() - gbase);
        end else begin
            tests_bad++;
            $display("test %s FAILED, %0d errors", name, errs);
        end
    endtask

    task automatic do_line(input string name, input int x0, y0, x1, y1,
                           input logic [colw-1:0] c, inout int errs);
        model_line(x0, y0, x1, y1, c);
        run_cmd(name, op_line, x0, y0, x1, y1, 0, 0, c, errs);
    endtask

    task automatic test_lines();
        int errs, gbase;
        errs  = 0;
        gbase = got_q.size();
        exp_q.delete();
        do_line("lines", 10, 20, 30, 20, 8'h11, errs);      // horizontal
        do_line("lines", 100, 100, 105, 120, 8'h12, errs);  // steep, down right
        do_line("lines", 100, 100, 95, 120, 8'h13, errs);   // down left
        do_line("lines", 100, 100, 106, 82, 8'h14, errs);   // up right
        do_line("lines", 100, 100, 93, 81, 8'h15, errs);    // up left
        report_test("lines", gbase, errs);
    endtask

    task automatic test_triangle();
        int errs, gbase;
        errs  = 0;
        gbase = got_q.size();
        exp_q.delete();
        model_line(50, 50, 80, 60, 8'h21);
        model_line(80, 60, 60, 90, 8'h21);
        model_line(60, 90, 50, 50, 8'h21);
        run_cmd("triangle", op_tri, 50, 50, 80, 60, 60, 90, 8'h21, errs);
        model_line(200, 200, 200, 200, 8'h22);             // p0 = p1
        model_line(200, 200, 220, 210, 8'h22);
        model_line(220, 210, 200, 200, 8'h22);
        run_cmd("triangle", op_tri, 200, 200, 200, 200, 220, 210, 8'h22, errs);
        report_test("triangle", gbase, errs);
    endtask

    task automatic test_rect();
        int errs, gbase;
        errs  = 0;
        gbase = got_q.size();
        exp_q.delete();
        model_rect(40, 30, 33, 26, 8'h31);                 // swapped corners, 8 x 5
        run_cmd("rect", op_rect, 40, 30, 33, 26, 0, 0, 8'h31, errs);
        if (got_q.size() - gbase != 40) begin
            $display("MISMATCH rect area expected 40 actual %0d", got_q.size() - gbase);
            errs++;
        end
        report_test("rect", gbase, errs);
    endtask

    task automatic test_clip();
        int errs, gbase;
        errs  = 0;
        gbase = got_q.size();
        exp_q.delete();
        do_line("clip", 620, 470, 660, 478, 8'h41, errs);  // past x = 639
        do_line("clip", 300, 470, 310, 495, 8'h42, errs);  // past y = 479
        do_line("clip", 700, 10, 630, 12, 8'h43, errs);    // starts off screen
        report_test("clip", gbase, errs);
    endtask

    task automatic test_random_stall();
        int errs, gbase;
        errs  = 0;
        gbase = got_q.size();
        exp_q.delete();
        rand_ready = 1'b1;
        do_line("random_stall", 0, 0, 300, 200, 8'h5a, errs);
        rand_ready = 1'b0;
        report_test("random_stall", gbase, errs);
    endtask

    // second command waits on the handshake during the first draw
    task automatic test_back_to_back();
        int errs, gbase, base;
        bit ok;
        errs  = 0;
        gbase = got_q.size();
        base  = done_cnt;
        exp_q.delete();
        model_line(10, 10, 40, 25, 8'h61);
        model_rect(8, 7, 5, 5, 8'h62);
        drive_cmd(op_line, 10, 10, 40, 25, 0, 0, 8'h61);
        wait_accept(ok);
        drive_cmd(op_rect, 8, 7, 5, 5, 0, 0, 8'h62);      // valid stays high
        if (ok) wait_accept(ok);
        cmd_valid = 1'b0;
        if (!ok) begin
            $display("back_to_back: a command was never accepted");
            errs++;
        end else if (done_cnt != base + 1) begin
            $display("MISMATCH back_to_back dones before second accept expected 1 actual %0d",
                     done_cnt - base);
            errs++;
        end
        wait_done(base + 2, ok);
        if (!ok) begin
            $display("back_to_back: no done pulse after the second command");
            errs++;
        end
        report_test("back_to_back", gbase, errs);
    endtask

    initial begin
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = op_line;
        cmd_x0     = '0;
        cmd_y0     = '0;
        cmd_x1     = '0;
        cmd_y1     = '0;
        cmd_x2     = '0;
        cmd_y2     = '0;
        cmd_color  = '0;
        rand_ready = 1'b0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_lines();
        test_triangle();
        test_rect();
        test_clip();
        test_random_stall();
        test_back_to_back();
        assert_errs = i_draw_engine.i_draw_assertions.fail_cnt;
        $display("summary: %0d tests ok, %0d tests failed, %0d busy handshake errors, %0d %s",
                 tests_ok, tests_bad, busy_errs, assert_errs, "assertion failures");
        if (tests_bad == 0 && busy_errs == 0 && assert_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
draw_pkg.sv
line_raster.sv
rect_fill.sv
draw_ctrl.sv
pixel_out.sv
draw_engine.sv
draw_assertions.sv
tb_draw_engine.sv

// File: run_sim.sh
#!/bin/sh
# build the draw engine testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_draw_engine -o tb_draw_engine \
    && ./obj_dir/tb_draw_engine | tee /dev/stderr | grep -q "sim passed" \
    && echo "run ok" \
    || { echo "run FAILED"; exit 1; }
